//--- common/alu_ex_cfg.svh
`ifndef ALU_EX_CFG_SVH
`define ALU_EX_CFG_SVH

// datapath width of the execute stage
`define ALU_XLEN 64

// one product bit per cycle
`define MUL_STEPS 64

// one quotient bit per cycle
`define DIV_STEPS 64

// wide enough to count either iteration run
`define ITER_CNT_W 7

`endif

//--- common/alu_ex_pkg.sv
`include "alu_ex_cfg.svh"
`default_nettype none

package alu_ex_pkg;

  typedef logic [`ALU_XLEN-1:0] xlen_t;

  // [4] word, [3] variant, [2:0] function
  typedef logic [4:0] alu_op_t;

  // [2] divide, [1:0] kind
  typedef logic [2:0] md_op_t;

  typedef logic [`ITER_CNT_W-1:0] iter_cnt_t;

  typedef enum logic [1:0] {MD_IDLE, MD_BUSY, MD_HOLD} issue_state_t;

  typedef enum logic [1:0] {IT_IDLE, IT_RUN, IT_FIX} iter_state_t;

  // function field of alu_op_t
  localparam logic [2:0] FN_ADD = 3'd0;
  localparam logic [2:0] FN_SLL = 3'd1;
  localparam logic [2:0] FN_SLT = 3'd2;
  localparam logic [2:0] FN_SRC2 = 3'd3;
  localparam logic [2:0] FN_XOR = 3'd4;
  localparam logic [2:0] FN_SRL = 3'd5;
  localparam logic [2:0] FN_OR = 3'd6;
  localparam logic [2:0] FN_AND = 3'd7;

  // multiply kinds, md_op_t[1:0] with bit 2 clear
  localparam logic [1:0] MUL_MUL = 2'd0;
  localparam logic [1:0] MUL_MULH = 2'd1;
  localparam logic [1:0] MUL_MULHSU = 2'd2;
  localparam logic [1:0] MUL_MULHU = 2'd3;

endpackage

`default_nettype wire

//--- design/alu_shifter.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module alu_shifter import alu_ex_pkg::*; (
  input  wire xlen_t src_i,
  input  wire  [5:0] shamt_i,
  input  wire        right_i,
  input  wire        arith_i,
  input  wire        word_i,
  output xlen_t      shift_o
);

  logic               fill;
  logic [5:0]         amt;
  xlen_t              opnd;
  logic [`ALU_XLEN:0] ext_opnd;
  xlen_t              shifted;
  xlen_t              rev_back;

  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      r[i] = v[`ALU_XLEN-1-i];
    end
    return r;
  endfunction

  // sign of the operand that is actually being shifted
  assign fill = right_i & arith_i & (word_i ? src_i[31] : src_i[`ALU_XLEN-1]);

  // left shifts run through the same right shifter on a reversed operand
  assign opnd = !right_i ? bit_rev(src_i) :
                word_i   ? {{(`ALU_XLEN-32){fill}}, src_i[31:0]} :
                           src_i;

  // W forms use only five bits of the amount
  assign amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

  assign ext_opnd = {fill, opnd};
  assign shifted  = xlen_t'($signed(ext_opnd) >>> amt);
  assign rev_back = right_i ? shifted : bit_rev(shifted);

  // upper word is sign-extended again on the output side
  assign shift_o = word_i ? {{(`ALU_XLEN-32){fill}}, rev_back[31:0]} : rev_back;

endmodule

`default_nettype wire

//--- design/alu_int_core.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module alu_int_core import alu_ex_pkg::*; (
  input  wire alu_op_t alu_op_i,
  input  wire xlen_t   src1_i,
  input  wire xlen_t   src2_i,
  output xlen_t        int_res_o,
  output logic         less_o,
  output logic         zero_o
);

  logic [2:0] fn;
  logic       sub_en;
  logic       uns_cmp;
  logic       shr;
  logic       sha;
  xlen_t      b_x;
  xlen_t      sum;
  logic       carry;
  logic       ovf;
  xlen_t      shift_res;

  // opcode decode
  assign fn      = alu_op_i[2:0];
  assign sub_en  = alu_op_i[3] | (fn == FN_SLT);
  assign uns_cmp = alu_op_i[3];
  assign shr     = alu_op_i[2];
  assign sha     = alu_op_i[3];

  // subtract as a + ~b + 1
  assign b_x = src2_i ^ {`ALU_XLEN{sub_en}};
  assign {carry, sum} = {1'b0, src1_i} + {1'b0, b_x} + {{`ALU_XLEN{1'b0}}, sub_en};

  assign ovf = (src1_i[`ALU_XLEN-1] == b_x[`ALU_XLEN-1]) &&
               (sum[`ALU_XLEN-1] != src1_i[`ALU_XLEN-1]);

  // no carry out of a - b means a < b unsigned
  assign less_o = uns_cmp ? (carry ^ sub_en) : (sum[`ALU_XLEN-1] ^ ovf);
  assign zero_o = ~|sum;

  alu_shifter u_alu_shifter (
    .src_i   (src1_i),
    .shamt_i (src2_i[5:0]),
    .right_i (shr),
    .arith_i (sha),
    .word_i  (alu_op_i[4]),
    .shift_o (shift_res)
  );

  always_comb begin
    case (fn)
      FN_ADD:  int_res_o = sum;
      FN_SLL:  int_res_o = shift_res;
      FN_SLT:  int_res_o = {{(`ALU_XLEN-1){1'b0}}, less_o};
      FN_SRC2: int_res_o = src2_i;
      FN_XOR:  int_res_o = src1_i ^ src2_i;
      FN_SRL:  int_res_o = shift_res;
      FN_OR:   int_res_o = src1_i | src2_i;
      FN_AND:  int_res_o = src1_i & src2_i;
      default: int_res_o = sum;
    endcase
  end

endmodule

`default_nettype wire

//--- muldiv/muldiv_issue.sv
`default_nettype none

module muldiv_issue import alu_ex_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         md_en_i,
  input  wire md_op_t md_op_i,
  input  wire xlen_t  src1_i,
  input  wire xlen_t  src2_i,
  input  wire         flush_i,
  input  wire         mul_done_i,
  input  wire         div_done_i,
  output logic        mul_start_o,
  output logic        div_start_o,
  output logic        md_ready_o,
  output md_op_t      lock_op_o,
  output xlen_t       lock_a_o,
  output xlen_t       lock_b_o
);

  issue_state_t state_q;
  logic         start_q;
  logic         in_diff;
  logic         fire;
  logic         done_sel;

  assign in_diff = (src1_i != lock_a_o) || (src2_i != lock_b_o) || (md_op_i != lock_op_o);

  // new operation when idle or when the pipeline moved on to other operands
  assign fire = md_en_i & ~flush_i & ((state_q == MD_IDLE) | in_diff);

  // only the unit that owns the locked op may complete it
  assign done_sel = lock_op_o[2] ? div_done_i : mul_done_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= MD_IDLE;
      start_q   <= 1'b0;
      lock_op_o <= '0;
      lock_a_o  <= '0;
      lock_b_o  <= '0;
    end else begin
      start_q <= fire;
      if (fire) begin
        lock_op_o <= md_op_i;
        lock_a_o  <= src1_i;
        lock_b_o  <= src2_i;
      end
      if (flush_i || !md_en_i) begin
        state_q <= MD_IDLE;
      end else if (fire) begin
        state_q <= MD_BUSY;
      end else if (state_q == MD_BUSY && done_sel) begin
        state_q <= MD_HOLD;
      end
    end
  end

  assign mul_start_o = start_q & ~lock_op_o[2];
  assign div_start_o = start_q & lock_op_o[2];
  assign md_ready_o  = (state_q == MD_HOLD);

endmodule

`default_nettype wire

//--- muldiv/mul_iter.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module mul_iter import alu_ex_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        start_i,
  input  wire        flush_i,
  input  wire  [1:0] mul_type_i,
  input  wire xlen_t a_i,
  input  wire xlen_t b_i,
  output logic       done_o,
  output xlen_t      prod_o
);

  iter_state_t                 state_q;
  iter_cnt_t                   cnt_q;
  logic                        neg_q;
  logic                        high_q;
  // upper half collects partial sums, lower half holds the remaining multiplier
  logic [2*`ALU_XLEN-1:0]      acc_q;
  xlen_t                       mcand_q;
  logic                        a_sgn;
  logic                        b_sgn;
  xlen_t                       a_mag;
  xlen_t                       b_mag;
  logic [`ALU_XLEN:0]          part_sum;
  logic [2*`ALU_XLEN-1:0]      full_prod;

  // mulhsu treats only the first operand as signed
  assign a_sgn = ((mul_type_i == MUL_MULH) || (mul_type_i == MUL_MULHSU)) & a_i[`ALU_XLEN-1];
  assign b_sgn = (mul_type_i == MUL_MULH) & b_i[`ALU_XLEN-1];
  assign a_mag = a_sgn ? -a_i : a_i;
  assign b_mag = b_sgn ? -b_i : b_i;

  assign part_sum = {1'b0, acc_q[2*`ALU_XLEN-1:`ALU_XLEN]} +
                    {1'b0, mcand_q & {`ALU_XLEN{acc_q[0]}}};
  assign full_prod = neg_q ? -acc_q : acc_q;

  assign done_o = (state_q == IT_FIX);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IT_IDLE;
      cnt_q   <= '0;
      neg_q   <= 1'b0;
      high_q  <= 1'b0;
    end else if (flush_i) begin
      state_q <= IT_IDLE;
    end else if (start_i) begin
      state_q <= IT_RUN;
      cnt_q   <= '0;
      neg_q   <= a_sgn ^ b_sgn;
      high_q  <= (mul_type_i != MUL_MUL);
    end else begin
      case (state_q)
        IT_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == iter_cnt_t'(`MUL_STEPS - 1)) state_q <= IT_FIX;
        end
        IT_FIX:  state_q <= IT_IDLE;
        default: state_q <= IT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc_q   <= {{`ALU_XLEN{1'b0}}, b_mag};
      mcand_q <= a_mag;
    end else if (state_q == IT_RUN) begin
      acc_q <= {part_sum, acc_q[`ALU_XLEN-1:1]};
    end
  end

  // result stays put until the next completed run
  always_ff @(posedge clk) begin
    if (state_q == IT_FIX && !flush_i) begin
      prod_o <= high_q ? full_prod[2*`ALU_XLEN-1:`ALU_XLEN] : full_prod[`ALU_XLEN-1:0];
    end
  end

endmodule

`default_nettype wire

//--- muldiv/div_iter.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module div_iter import alu_ex_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        start_i,
  input  wire        flush_i,
  input  wire  [1:0] div_type_i,
  input  wire xlen_t a_i,
  input  wire xlen_t b_i,
  output logic       done_o,
  output xlen_t      res_o
);

  localparam xlen_t SIGNED_MIN = {1'b1, {(`ALU_XLEN-1){1'b0}}};

  iter_state_t        state_q;
  iter_cnt_t          cnt_q;
  logic               q_neg_q;
  logic               r_neg_q;
  logic               want_rem_q;
  logic               zero_div_q;
  logic               ovf_q;
  xlen_t              quo_q;
  xlen_t              rem_q;
  xlen_t              dvs_q;
  xlen_t              dvd_q;
  logic               signed_op;
  logic               a_neg;
  logic               b_neg;
  xlen_t              a_mag;
  xlen_t              b_mag;
  logic [`ALU_XLEN:0] r_sh;
  logic [`ALU_XLEN:0] r_sub;
  logic               ge;
  xlen_t              q_fix;
  xlen_t              r_fix;

  // div and rem are signed, divu and remu are not
  assign signed_op = ~div_type_i[0];
  assign a_neg = signed_op & a_i[`ALU_XLEN-1];
  assign b_neg = signed_op & b_i[`ALU_XLEN-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  // next dividend bit moves from the quotient register into the remainder
  assign r_sh  = {rem_q, quo_q[`ALU_XLEN-1]};
  assign r_sub = r_sh - {1'b0, dvs_q};
  assign ge    = (r_sh >= {1'b0, dvs_q});

  assign done_o = (state_q == IT_FIX);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IT_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= IT_IDLE;
    end else if (start_i) begin
      state_q <= IT_RUN;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IT_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == iter_cnt_t'(`DIV_STEPS - 1)) state_q <= IT_FIX;
        end
        IT_FIX:  state_q <= IT_IDLE;
        default: state_q <= IT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_q      <= a_mag;
      rem_q      <= '0;
      dvs_q      <= b_mag;
      dvd_q      <= a_i;
      q_neg_q    <= a_neg ^ b_neg;
      r_neg_q    <= a_neg;
      want_rem_q <= div_type_i[1];
      zero_div_q <= (b_i == '0);
      ovf_q      <= signed_op && (a_i == SIGNED_MIN) && (b_i == '1);
    end else if (state_q == IT_RUN) begin
      rem_q <= ge ? r_sub[`ALU_XLEN-1:0] : r_sh[`ALU_XLEN-1:0];
      quo_q <= {quo_q[`ALU_XLEN-2:0], ge};
    end
  end

  always_comb begin
    q_fix = q_neg_q ? -quo_q : quo_q;
    r_fix = r_neg_q ? -rem_q : rem_q;
    // RISC-V results for x/0 and min/-1, no trap
    if (zero_div_q) begin
      q_fix = '1;
      r_fix = dvd_q;
    end else if (ovf_q) begin
      q_fix = dvd_q;
      r_fix = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IT_FIX && !flush_i) begin
      res_o <= want_rem_q ? r_fix : q_fix;
    end
  end

endmodule

`default_nettype wire

//--- design/alu_result_sel.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module alu_result_sel import alu_ex_pkg::*; (
  input  wire        md_en_i,
  input  wire        word_i,
  input  wire xlen_t int_res_i,
  input  wire xlen_t md_res_i,
  input  wire        md_ready_i,
  output xlen_t      result_o,
  output logic       not_ok_o
);

  xlen_t int_ext;

  // W forms keep 32 bits and extend the sign
  assign int_ext = word_i ? {{(`ALU_XLEN-32){int_res_i[31]}}, int_res_i[31:0]} : int_res_i;

  // mul/div always runs full width, the word flag is ignored there
  assign result_o = md_en_i ? md_res_i : int_ext;

  // pipeline holds while a mul/div is outstanding
  assign not_ok_o = md_en_i & ~md_ready_i;

endmodule

`default_nettype wire

//--- design/alu_ex_top.sv
`default_nettype none

module alu_ex_top import alu_ex_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire alu_op_t alu_op_i,
  input  wire xlen_t   src1_i,
  input  wire xlen_t   src2_i,
  input  wire          md_en_i,
  input  wire md_op_t  md_op_i,
  input  wire          flush_i,
  output xlen_t        result_o,
  output logic         less_o,
  output logic         zero_o,
  output logic         not_ok_o
);

  xlen_t  int_res;
  xlen_t  mul_res;
  xlen_t  div_res;
  xlen_t  md_res;
  xlen_t  lock_a;
  xlen_t  lock_b;
  md_op_t lock_op;
  logic   mul_start;
  logic   div_start;
  logic   mul_done;
  logic   div_done;
  logic   md_ready;

  alu_int_core u_alu_int_core (
    .alu_op_i  (alu_op_i),
    .src1_i    (src1_i),
    .src2_i    (src2_i),
    .int_res_o (int_res),
    .less_o    (less_o),
    .zero_o    (zero_o)
  );

  muldiv_issue u_muldiv_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .md_en_i     (md_en_i),
    .md_op_i     (md_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .flush_i     (flush_i),
    .mul_done_i  (mul_done),
    .div_done_i  (div_done),
    .mul_start_o (mul_start),
    .div_start_o (div_start),
    .md_ready_o  (md_ready),
    .lock_op_o   (lock_op),
    .lock_a_o    (lock_a),
    .lock_b_o    (lock_b)
  );

  mul_iter u_mul_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (mul_start),
    .flush_i    (flush_i),
    .mul_type_i (lock_op[1:0]),
    .a_i        (lock_a),
    .b_i        (lock_b),
    .done_o     (mul_done),
    .prod_o     (mul_res)
  );

  div_iter u_div_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .flush_i    (flush_i),
    .div_type_i (lock_op[1:0]),
    .a_i        (lock_a),
    .b_i        (lock_b),
    .done_o     (div_done),
    .res_o      (div_res)
  );

  // held result of whichever unit owns the locked op
  assign md_res = lock_op[2] ? div_res : mul_res;

  alu_result_sel u_alu_result_sel (
    .md_en_i    (md_en_i),
    .word_i     (alu_op_i[4]),
    .int_res_i  (int_res),
    .md_res_i   (md_res),
    .md_ready_i (md_ready),
    .result_o   (result_o),
    .not_ok_o   (not_ok_o)
  );

endmodule

`default_nettype wire

//--- verif/alu_ex_ref_model.svh
`ifndef ALU_EX_REF_MODEL_SVH
`define ALU_EX_REF_MODEL_SVH

// adder subtracts for the variant and for every set-less-than
function automatic logic uses_sub(input alu_op_t op);
  return op[3] || (op[2:0] == 3'd2);
endfunction

function automatic xlen_t adder_out(input alu_op_t op, input xlen_t a, input xlen_t b);
  return uses_sub(op) ? a - b : a + b;
endfunction

function automatic logic adder_zero(input alu_op_t op, input xlen_t a, input xlen_t b);
  return adder_out(op, a, b) == '0;
endfunction

function automatic logic cmp_less(input alu_op_t op, input xlen_t a, input xlen_t b);
  logic [`ALU_XLEN:0] exact_sum;
  logic               res;
  exact_sum = {a[`ALU_XLEN-1], a} + {b[`ALU_XLEN-1], b};
  if (op[3]) begin
    res = a < b;
  end else if (op[2:0] == 3'd2) begin
    res = $signed(a) < $signed(b);
  end else begin
    // plain add gives the sign of the exact sum
    res = exact_sum[`ALU_XLEN];
  end
  return res;
endfunction

function automatic xlen_t sext_word(input logic [31:0] w);
  return {{(`ALU_XLEN-32){w[31]}}, w};
endfunction

function automatic xlen_t shift_result(input alu_op_t op, input xlen_t a, input xlen_t b);
  logic [31:0] lo;
  logic [31:0] w;
  xlen_t       r;
  lo = a[31:0];
  if (op[4]) begin
    // W forms shift the low word by five bits of src2
    if (op[2:0] == 3'd1) w = lo << b[4:0];
    else if (op[3]) w = $signed(lo) >>> b[4:0];
    else w = lo >> b[4:0];
    r = sext_word(w);
  end else begin
    if (op[2:0] == 3'd1) r = a << b[5:0];
    else if (op[3]) r = $signed(a) >>> b[5:0];
    else r = a >> b[5:0];
  end
  return r;
endfunction

function automatic xlen_t int_result(input alu_op_t op, input xlen_t a, input xlen_t b);
  xlen_t r;
  case (op[2:0])
    3'd0:       r = adder_out(op, a, b);
    3'd1, 3'd5: r = shift_result(op, a, b);
    3'd2:       r = {{(`ALU_XLEN-1){1'b0}}, cmp_less(op, a, b)};
    3'd3:       r = b;
    3'd4:       r = a ^ b;
    3'd6:       r = a | b;
    default:    r = a & b;
  endcase
  if (op[4]) r = sext_word(r[31:0]);
  return r;
endfunction

function automatic xlen_t mul_result(input logic [1:0] kind, input xlen_t a, input xlen_t b);
  logic [2*`ALU_XLEN-1:0] ea;
  logic [2*`ALU_XLEN-1:0] eb;
  logic [2*`ALU_XLEN-1:0] p;
  // mulh and mulhsu take a as signed, only mulh takes b as signed
  ea = (kind == 2'd1 || kind == 2'd2) ? {{`ALU_XLEN{a[`ALU_XLEN-1]}}, a} : {{`ALU_XLEN{1'b0}}, a};
  eb = (kind == 2'd1) ? {{`ALU_XLEN{b[`ALU_XLEN-1]}}, b} : {{`ALU_XLEN{1'b0}}, b};
  p = ea * eb;
  return (kind == 2'd0) ? p[`ALU_XLEN-1:0] : p[2*`ALU_XLEN-1:`ALU_XLEN];
endfunction

function automatic xlen_t div_result(input logic [1:0] kind, input xlen_t a, input xlen_t b);
  xlen_t q;
  xlen_t r;
  xlen_t smin;
  logic  sgn;
  smin = {1'b1, {(`ALU_XLEN-1){1'b0}}};
  sgn = ~kind[0];
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (sgn && a == smin && b == '1) begin
    q = a;
    r = '0;
  end else if (sgn) begin
    q = $signed(a) / $signed(b);
    r = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    r = a % b;
  end
  return kind[1] ? r : q;
endfunction

function automatic xlen_t muldiv_result(input md_op_t op, input xlen_t a, input xlen_t b);
  return op[2] ? div_result(op[1:0], a, b) : mul_result(op[1:0], a, b);
endfunction

`endif

//--- verif/alu_ex_tb.sv
`include "alu_ex_cfg.svh"
`default_nettype none

module alu_ex_tb import alu_ex_pkg::*; ();

  localparam logic [31:0] SEED = 32'h426b91c4;
  localparam xlen_t SMIN = {1'b1, {(`ALU_XLEN-1){1'b0}}};
  localparam int N_INT = 300;
  localparam int N_WORD = 200;
  localparam int N_MUL = 40;
  localparam int N_DIV = 40;
  localparam int N_B2B = 10;
  localparam int N_FLUSH = 10;
  // cycles from md_en sampled high until not_ok_o falls
  localparam int MD_LATENCY = 66;
  // five mul/div ops per chain and two for each flushed op
  localparam int MD_OPS = N_MUL + N_DIV + 8 + 5 * N_B2B + 2 * N_FLUSH;
  localparam int WD_CYCLES = (MD_OPS + N_INT + N_WORD + 97) * 80 + 1000;

  logic        clk;
  logic        rst_n;
  alu_op_t     alu_op;
  xlen_t       src1;
  xlen_t       src2;
  logic        md_en;
  md_op_t      md_op;
  logic        flush;
  xlen_t       result;
  logic        less;
  logic        zero;
  logic        not_ok;
  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          tests;
  int          base_err;

  `include "alu_ex_ref_model.svh"

  alu_ex_top u_alu_ex_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .alu_op_i (alu_op),
    .src1_i   (src1),
    .src2_i   (src2),
    .md_en_i  (md_en),
    .md_op_i  (md_op),
    .flush_i  (flush),
    .result_o (result),
    .less_o   (less),
    .zero_o   (zero),
    .not_ok_o (not_ok)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic xlen_t pick_operand();
    logic [2:0] c;
    xlen_t      v;
    c = 3'(rand_bits(3));
    case (c)
      3'd0:    v = '0;
      3'd1:    v = '1;
      3'd2:    v = SMIN;
      default: v = xlen_t'(rand_bits(`ALU_XLEN));
    endcase
    return v;
  endfunction

  // inputs change one unit after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %b, actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int ops);
    $display("test %-6s done: %0d ops, %0d errors", name, ops, errors - base_err);
    base_err = errors;
    tests++;
  endtask

  task automatic run_int(input alu_op_t op, input xlen_t a, input xlen_t b);
    md_en = 1'b0;
    alu_op = op;
    src1 = a;
    src2 = b;
    #2;
    check_val("result_o", int_result(op, a, b), result);
    check_bit("less_o", cmp_less(op, a, b), less);
    check_bit("zero_o", adder_zero(op, a, b), zero);
    check_bit("not_ok_o", 1'b0, not_ok);
    tick();
  endtask

  // flush_at above zero pulses flush_i that many cycles into the op
  task automatic run_md(input md_op_t op, input xlen_t a, input xlen_t b,
                        input logic from_idle, input int flush_at);
    int    cycles;
    xlen_t exp;
    exp = muldiv_result(op, a, b);
    md_en = 1'b1;
    md_op = op;
    src1 = a;
    src2 = b;
    alu_op = alu_op_t'(rand_bits(5));
    #1;
    if (from_idle) check_bit("not_ok_o", 1'b1, not_ok);
    tick();
    if (flush_at > 0) begin
      repeat (flush_at) tick();
      flush = 1'b1;
      tick();
      flush = 1'b0;
    end
    cycles = 0;
    while (not_ok && cycles < 80) begin
      tick();
      cycles++;
    end
    checks++;
    assert (!not_ok) else begin
      $display("at %0t not_ok_o still high 80 cycles into md op %0d", $time, op);
      errors++;
    end
    if (flush_at > 0) begin
      checks++;
      // the restarted op needs the whole latency again
      assert (cycles >= MD_LATENCY) else begin
        $display("at %0t not_ok_o fell %0d cycles after flush_i, so the op did not restart",
                 $time, cycles);
        errors++;
      end
    end
    check_val("result_o", exp, result);
    repeat (3) tick();
    // held result while md_en stays high
    check_val("result_o", exp, result);
    check_bit("not_ok_o", 1'b0, not_ok);
  endtask

  task automatic drop_md();
    md_en = 1'b0;
    tick();
  endtask

  initial begin
    alu_op_t op;
    md_op_t  mop;
    md_op_t  nmop;
    xlen_t   a;
    xlen_t   b;
    xlen_t   na;
    xlen_t   nb;
    lfsr_q = SEED;
    errors = 0;
    checks = 0;
    tests = 0;
    base_err = 0;
    rst_n = 1'b0;
    alu_op = '0;
    src1 = '0;
    src2 = '0;
    md_en = 1'b0;
    md_op = '0;
    flush = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("not_ok_o", 1'b0, not_ok);
    end_test("reset", 1);

    for (int i = 0; i < N_INT; i++) begin
      op = alu_op_t'(rand_bits(5));
      op[4] = 1'b0;
      run_int(op, pick_operand(), pick_operand());
    end
    end_test("int", N_INT);

    // every W shift amount before the random word ops
    for (int k = 0; k < 3; k++) begin
      for (int amt = 0; amt < 32; amt++) begin
        op = (k == 0) ? 5'b10001 : (k == 1) ? 5'b10101 : 5'b11101;
        b = xlen_t'(rand_bits(`ALU_XLEN));
        b[4:0] = 5'(amt);
        run_int(op, pick_operand(), b);
      end
    end
    for (int i = 0; i < N_WORD; i++) begin
      op = alu_op_t'(rand_bits(5));
      op[4] = 1'b1;
      run_int(op, pick_operand(), pick_operand());
    end
    end_test("word", N_WORD + 96);

    for (int i = 0; i < N_MUL; i++) begin
      mop = {1'b0, 2'(rand_bits(2))};
      run_md(mop, pick_operand(), pick_operand(), 1'b1, 0);
      drop_md();
    end
    end_test("mul", N_MUL);

    for (int k = 0; k < 4; k++) begin
      mop = {1'b1, 2'(k)};
      run_md(mop, pick_operand(), '0, 1'b1, 0);
      drop_md();
      run_md(mop, SMIN, '1, 1'b1, 0);
      drop_md();
    end
    for (int i = 0; i < N_DIV; i++) begin
      mop = {1'b1, 2'(rand_bits(2))};
      run_md(mop, pick_operand(), pick_operand(), 1'b1, 0);
      drop_md();
    end
    end_test("div", N_DIV + 8);

    for (int i = 0; i < N_B2B; i++) begin
      mop = md_op_t'(rand_bits(3));
      a = pick_operand();
      b = pick_operand();
      run_md(mop, a, b, 1'b1, 0);
      for (int k = 0; k < 3; k++) begin
        nmop = md_op_t'(rand_bits(3));
        na = pick_operand();
        nb = pick_operand();
        if (na == a && nb == b && nmop == mop) na[0] = ~na[0];
        mop = nmop;
        a = na;
        b = nb;
        run_md(mop, a, b, 1'b0, 0);
      end
      // same inputs again once md_en has dropped
      drop_md();
      run_md(mop, a, b, 1'b1, 0);
      drop_md();
    end
    end_test("b2b", 5 * N_B2B);

    for (int i = 0; i < N_FLUSH; i++) begin
      mop = md_op_t'(rand_bits(3));
      run_md(mop, pick_operand(), pick_operand(), 1'b1, int'(rand_bits(5)) + 16);
      drop_md();
    end
    end_test("flush", N_FLUSH);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- alu_ex.f
+incdir+common
+incdir+verif
common/alu_ex_pkg.sv
design/alu_shifter.sv
design/alu_int_core.sv
muldiv/muldiv_issue.sv
muldiv/mul_iter.sv
muldiv/div_iter.sv
design/alu_result_sel.sv
design/alu_ex_top.sv
verif/alu_ex_tb.sv

//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat alu_ex.f))
HDRS := $(wildcard common/*.svh verif/*.svh)

.PHONY: run clean

run: obj_dir/Valu_ex_tb
	./obj_dir/Valu_ex_tb | tee sim.log
	grep -q "Simulation PASSED" sim.log

obj_dir/Valu_ex_tb: alu_ex.f $(SRCS) $(HDRS)
	verilator --binary --timing --assert --top-module alu_ex_tb -f alu_ex.f -o Valu_ex_tb

clean:
	rm -rf obj_dir sim.log
